// ==== verification/video_capture_tests.txt ====
// columns y0 y1 cb cr then the rgb565 words expected for y0 and y1
// one field per line, all values hex
80 40 80 80 8410 31a6
51 91 5a f0 f800 fa49
29 c8 f0 6e 001f bddf
10 eb 80 80 0000 ffff
ff 00 80 80 ffff 0000
ff 00 00 ff ff02 b800

// ==== flist.f ====
+incdir+hw
hw/vcap_pkg.sv
hw/ycbcr_unpack.sv
hw/ycbcr_to_rgb565.sv
hw/frame_writer.sv
hw/frame_buffer.sv
hw/video_capture_top.sv
verification/video_capture_sva.sv
verification/video_capture_tb.sv

// ==== Makefile ====
# Verilator flow for the video capture testbench

TOP = video_capture_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== verification/video_capture_tb.sv ====
//----------------------------------------------------------
// video capture testbench
// odd fields from the tests file, bank readback, irq checks
//----------------------------------------------------------
`timescale 1ns/1ps
`include "vcap_params.svh"

module video_capture_tb;

   localparam int NUM_REC  = 6;       // frames in the tests file
   localparam int REC_LEN  = 6;       // y0 y1 cb cr exp0 exp1
   localparam int WAIT_MAX = 2000;    // cycles per wait loop

   logic                  clk_llc;
   logic                  resetx;
   vcap_pkg::vid_in_t     vid;
   vcap_pkg::rd_req_t     req;
   logic                  req_valid;
   logic                  req_ready;
   vcap_pkg::rd_rsp_t     rsp;
   logic                  rsp_valid;
   logic                  rsp_ready;
   vcap_pkg::frame_irq_t  irq;

   logic [15:0]           tests [NUM_REC*REC_LEN];
   logic [31:0]           lfsr = 32'h897dae6d;
   int                    irq_count = 0;
   vcap_pkg::frame_irq_t  last_irq = '0;

   video_capture_top uut
   (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .vid        (vid),
      .req        (req),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .rsp        (rsp),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .irq        (irq)
   );

   initial
   begin
      clk_llc = 1'b0;
      forever #4 clk_llc = ~clk_llc;   // 8 ns period
   end

   // irq monitor, sampled mid cycle
   always @(negedge clk_llc)
   begin
      if (resetx && irq.pulse)
      begin
         irq_count = irq_count + 1;
         last_irq  = irq;
      end
   end

   //----------------------------------------------------------
   // helpers
   //----------------------------------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   task automatic compare_pixel(input string name, input vcap_pkg::rgb565_t got,
                                input vcap_pkg::rgb565_t exp);
      if (got !== exp)
         abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
   endtask

   task automatic compare_irq_bank(input vcap_pkg::frame_irq_t got, input logic exp_bank);
      if (got.bank !== exp_bank)
         abort_run($sformatf("FAILED irq.bank got %h expected %h", got.bank, exp_bank));
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);                 // one step per bit
         val  = (val << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic after_rising_edge();
      @(posedge clk_llc);
      #1;
   endtask

   task automatic drive_vid(input logic vref, input logic href, input logic [7:0] data);
      after_rising_edge();
      vid.vref = vref;
      vid.href = href;
      vid.odd  = 1'b1;                           // odd fields only
      vid.data = data;
   endtask

   //----------------------------------------------------------
   // one odd field of a record
   //----------------------------------------------------------
   task automatic drive_field(input int rec);
      logic [7:0] seq [4];
      int         blank;
      seq[0] = tests[rec*REC_LEN+2][7:0];        // cb
      seq[1] = tests[rec*REC_LEN+0][7:0];        // y0
      seq[2] = tests[rec*REC_LEN+3][7:0];        // cr
      seq[3] = tests[rec*REC_LEN+1][7:0];        // y1
      take_bits(3, blank);
      repeat (blank + 2)
         drive_vid(1'b1, 1'b0, 8'h00);           // field open, no line yet
      for (int ln = 0; ln < `VC_SRC_LINES; ln++)
      begin
         for (int b = 0; b < 2*`VC_SRC_WIDTH; b++)
            drive_vid(1'b1, 1'b1, seq[b % 4]);
         take_bits(3, blank);
         repeat (blank + 1)
            drive_vid(1'b1, 1'b0, 8'h00);        // horizontal blanking
      end
      if (irq_count != rec)
         abort_run("frame interrupt seen before the field ended");
      repeat (8)
         drive_vid(1'b0, 1'b0, 8'h00);           // vertical blanking
   endtask

   //----------------------------------------------------------
   // host reads
   //----------------------------------------------------------
   task automatic read_word(input int addr, input vcap_pkg::rgb565_t exp);
      int cyc;
      int stall;
      cyc = 0;
      after_rising_edge();
      req.addr  = addr[`VC_ADDR_W-1:0];
      req_valid = 1'b1;
      @(negedge clk_llc);
      while (!req_ready)
      begin
         cyc++;
         if (cyc > WAIT_MAX)
            abort_run("timeout while waiting for req_ready");
         @(negedge clk_llc);
      end
      after_rising_edge();                       // request taken on that edge
      req_valid = 1'b0;

      // response due in the second cycle after the transfer
      cyc = 1;
      @(negedge clk_llc);
      while (!rsp_valid)
      begin
         compare_flag("req_ready", req_ready, 1'b0);
         cyc++;
         if (cyc > WAIT_MAX)
            abort_run("timeout while waiting for rsp_valid");
         @(negedge clk_llc);
      end
      if (cyc != 2)
         abort_run($sformatf("FAILED rsp_valid latency got %h expected %h", cyc, 2));

      take_bits(2, stall);
      repeat (stall)
      begin
         compare_flag("rsp_valid", rsp_valid, 1'b1);   // held under back-pressure
         compare_flag("req_ready", req_ready, 1'b0);
         compare_pixel("rsp.pixel", rsp.pixel, exp);
         @(negedge clk_llc);
      end
      compare_flag("rsp_valid", rsp_valid, 1'b1);
      compare_pixel("rsp.pixel", rsp.pixel, exp);
      after_rising_edge();
      rsp_ready = 1'b1;
      @(negedge clk_llc);
      compare_flag("rsp_valid", rsp_valid, 1'b1);
      compare_pixel("rsp.pixel", rsp.pixel, exp);
      after_rising_edge();                       // word taken
      rsp_ready = 1'b0;
      @(negedge clk_llc);
      compare_flag("rsp_valid", rsp_valid, 1'b0);
      compare_flag("req_ready", req_ready, 1'b1);
   endtask

   // kept columns 0 3 6 9 alternate y0 y1
   task automatic read_bank(input int rec);
      vcap_pkg::rgb565_t exp;
      for (int a = 0; a < `VC_BANK_WORDS; a++)
      begin
         exp = (a % 2 == 0) ? tests[rec*REC_LEN+4] : tests[rec*REC_LEN+5];
         read_word(a, exp);
      end
   endtask

   task automatic wait_irq(input int n, input logic exp_bank);
      int cyc;
      cyc = 0;
      while (irq_count < n)
      begin
         cyc++;
         if (cyc > WAIT_MAX)
            abort_run("timeout while waiting for the frame interrupt");
         @(negedge clk_llc);
      end
      if (irq_count != n)
         abort_run($sformatf("FAILED irq count got %h expected %h", irq_count, n));
      compare_irq_bank(last_irq, exp_bank);
   endtask

   //----------------------------------------------------------
   // main sequence
   //----------------------------------------------------------
   initial
   begin
      vid       = '0;
      req       = '0;
      req_valid = 1'b0;
      rsp_ready = 1'b0;
      resetx    = 1'b0;
      $readmemh("verification/video_capture_tests.txt", tests);
      repeat (3)
         @(posedge clk_llc);
      #1;
      resetx = 1'b1;

      @(negedge clk_llc);
      compare_flag("rsp_valid", rsp_valid, 1'b0);
      compare_flag("req_ready", req_ready, 1'b1);

      drive_field(0);
      wait_irq(1, 1'b0);                         // first field lands in bank 0
      for (int rec = 1; rec < NUM_REC; rec++)
      begin
         // previous frame read back while the next one is written
         fork
            drive_field(rec);
            read_bank(rec - 1);
         join
         wait_irq(rec + 1, rec[0]);
      end
      read_bank(NUM_REC - 1);

      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== verification/video_capture_sva.sv ====
//----------------------------------------------------------
// capture assertions, frame irq and host read handshake
//----------------------------------------------------------
`timescale 1ns/1ps

module video_capture_sva
(
   input logic                  clk_llc,
   input logic                  resetx,
   input vcap_pkg::frame_irq_t  irq,
   input logic                  req_valid,
   input logic                  req_ready,
   input vcap_pkg::rd_rsp_t     rsp,
   input logic                  rsp_valid,
   input logic                  rsp_ready
);

   // irq lasts one cycle
   a_irq_single : assert property (@(posedge clk_llc) disable iff (!resetx)
      irq.pulse |=> !irq.pulse)
      else $error("irq pulse longer than one cycle");

   // fetch cycle, then valid
   a_rsp_latency : assert property (@(posedge clk_llc) disable iff (!resetx)
      (req_valid && req_ready) |=> !rsp_valid ##1 rsp_valid)
      else $error("response not valid in the second cycle after the request");

   a_rsp_hold : assert property (@(posedge clk_llc) disable iff (!resetx)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
      else $error("response dropped or changed before it was taken");

   // busy from the request until the word is taken
   a_one_in_flight : assert property (@(posedge clk_llc) disable iff (!resetx)
      ((req_valid && req_ready) || (!req_ready && !(rsp_valid && rsp_ready)))
      |=> !req_ready)
      else $error("request accepted while a response is pending");

endmodule

// irq side, handshake inputs idle
bind frame_writer video_capture_sva u_irq_sva
(
   .clk_llc   (clk_llc),
   .resetx    (resetx),
   .irq       (irq),
   .req_valid (1'b0),
   .req_ready (1'b1),
   .rsp       ('0),
   .rsp_valid (1'b0),
   .rsp_ready (1'b0)
);

// host side, irq idle
bind frame_buffer video_capture_sva u_host_sva
(
   .clk_llc   (clk_llc),
   .resetx    (resetx),
   .irq       ('0),
   .req_valid (req_valid),
   .req_ready (req_ready),
   .rsp       (rsp),
   .rsp_valid (rsp_valid),
   .rsp_ready (rsp_ready)
);

// ==== hw/video_capture_top.sv ====
//----------------------------------------------------------
// video capture top
// decoder stream to rgb565 banks, host read port
//----------------------------------------------------------
`timescale 1ns/1ps

module video_capture_top
(
   input  logic                  clk_llc,
   input  logic                  resetx,
   input  vcap_pkg::vid_in_t     vid,
   input  vcap_pkg::rd_req_t     req,
   input  logic                  req_valid,
   output logic                  req_ready,
   output vcap_pkg::rd_rsp_t     rsp,
   output logic                  rsp_valid,
   input  logic                  rsp_ready,
   output vcap_pkg::frame_irq_t  irq
);

   vcap_pkg::ycbcr_pair_t  pair;
   logic                   pair_valid;
   vcap_pkg::rgb565_t      pix;
   logic                   pix_valid;
   vcap_pkg::fb_write_t    wr;

   // byte stream -> pixel pairs
   ycbcr_unpack u_unpack
   (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .vid        (vid),
      .pair       (pair),
      .pair_valid (pair_valid)
   );

   // pairs -> rgb565 pixels
   ycbcr_to_rgb565 u_csc
   (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .pair       (pair),
      .pair_valid (pair_valid),
      .pix        (pix),
      .pix_valid  (pix_valid)
   );

   frame_writer u_writer
   (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .vid        (vid),
      .pix        (pix),
      .pix_valid  (pix_valid),
      .wr         (wr),
      .irq        (irq)
   );

   frame_buffer u_fb
   (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .wr         (wr),
      .req        (req),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .rsp        (rsp),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready)
   );

endmodule

// ==== hw/frame_buffer.sv ====
//----------------------------------------------------------
// frame buffer, two pixel banks with a host read port
//----------------------------------------------------------
`timescale 1ns/1ps
`include "vcap_params.svh"

module frame_buffer
(
   input  logic                 clk_llc,
   input  logic                 resetx,
   input  vcap_pkg::fb_write_t  wr,
   input  vcap_pkg::rd_req_t    req,
   input  logic                 req_valid,
   output logic                 req_ready,
   output vcap_pkg::rd_rsp_t    rsp,
   output logic                 rsp_valid,
   input  logic                 rsp_ready
);

   localparam int MEM_AW = `VC_ADDR_W + 1;   // bank bit on top

   vcap_pkg::rgb565_t    mem [2*`VC_BANK_WORDS];
   vcap_pkg::rd_state_e  state;
   logic [MEM_AW-1:0]    rd_addr;
   vcap_pkg::rgb565_t    rd_word;
   logic                 req_fire;

   assign req_ready = (state == vcap_pkg::RD_IDLE);
   assign req_fire  = req_valid & req_ready;

   //----------------------------------------------------------
   // capture side write
   //----------------------------------------------------------
   always_ff @(posedge clk_llc)
   begin
      if (wr.en)
         mem[{wr.bank, wr.addr}] <= wr.pixel;
   end

   //----------------------------------------------------------
   // host read FSM
   // idle -> fetch (ram read) -> hold until taken
   //----------------------------------------------------------
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
         state <= vcap_pkg::RD_IDLE;
      else
      begin
         case (state)
            vcap_pkg::RD_IDLE :
            begin
               if (req_valid)
                  state <= vcap_pkg::RD_FETCH;
            end
            vcap_pkg::RD_FETCH :
               state <= vcap_pkg::RD_HOLD;
            vcap_pkg::RD_HOLD :
            begin
               if (rsp_ready)
                  state <= vcap_pkg::RD_IDLE;    // word taken
            end
            default :
               state <= vcap_pkg::RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_llc)
   begin
      if (req_fire)
         rd_addr <= {~wr.bank, req.addr};        // host sees the idle bank
      if (state == vcap_pkg::RD_FETCH)
         rd_word <= mem[rd_addr];                // registered read, held in RD_HOLD
   end

   assign rsp_valid = (state == vcap_pkg::RD_HOLD);
   assign rsp.pixel = rd_word;

endmodule

// ==== hw/frame_writer.sv ====
//----------------------------------------------------------
// frame writer
// decimation, bank addressing, bank swap and frame irq
//----------------------------------------------------------
`timescale 1ns/1ps
`include "vcap_params.svh"

module frame_writer
(
   input  logic                  clk_llc,
   input  logic                  resetx,
   input  vcap_pkg::vid_in_t     vid,
   input  vcap_pkg::rgb565_t     pix,
   input  logic                  pix_valid,
   output vcap_pkg::fb_write_t   wr,
   output vcap_pkg::frame_irq_t  irq
);

   // sync delay so line and field ends land behind the last pixel
   // leaving the colour pipeline
   localparam int CTL_LAT = 6;
   localparam int COL_W   = $clog2(`VC_SRC_WIDTH);
   localparam int PH_W    = $clog2(`VC_DECIM);

   logic [CTL_LAT-1:0]    fld_sr;      // odd field active, delayed
   logic [CTL_LAT-1:0]    hrf_sr;      // captured line active, delayed
   logic                  fld_fall;
   logic                  hrf_fall;

   logic [COL_W-1:0]      col;         // source pixel in line
   logic [PH_W-1:0]       col_ph;      // column mod decim
   logic [PH_W-1:0]       line_ph;     // line mod decim
   logic [`VC_ADDR_W-1:0] addr;
   logic                  bank;
   logic                  keep;

   logic                     wr_en_q;
   logic [`VC_ADDR_W-1:0]    wr_addr_q;
   vcap_pkg::rgb565_t        wr_pix_q;

   //----------------------------------------------------------
   // sync edges
   //----------------------------------------------------------
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         fld_sr <= '0;
         hrf_sr <= '0;
      end
      else
      begin
         fld_sr <= {fld_sr[CTL_LAT-2:0], vid.vref & vid.odd};
         hrf_sr <= {hrf_sr[CTL_LAT-2:0], vid.vref & vid.odd & vid.href};
      end
   end

   assign fld_fall = fld_sr[CTL_LAT-1] & ~fld_sr[CTL_LAT-2];   // end of odd field
   assign hrf_fall = hrf_sr[CTL_LAT-1] & ~hrf_sr[CTL_LAT-2];   // end of line

   // keep column 0, D, 2D .. on line 0, D, 2D ..
   assign keep = pix_valid && (col_ph == '0) && (line_ph == '0);

   //----------------------------------------------------------
   // counters, bank and irq
   //----------------------------------------------------------
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         col     <= '0;
         col_ph  <= '0;
         line_ph <= '0;
         addr    <= '0;
         bank    <= 1'b0;
         irq     <= '0;
         wr_en_q <= 1'b0;
      end
      else
      begin
         if (hrf_fall)
         begin
            col    <= '0;
            col_ph <= '0;
         end
         else if (pix_valid)
         begin
            if (col == COL_W'(`VC_SRC_WIDTH - 1))
            begin
               col    <= '0;                       // line wrap
               col_ph <= '0;
            end
            else
            begin
               col    <= col + 1'b1;
               col_ph <= (col_ph == PH_W'(`VC_DECIM - 1)) ? '0 : col_ph + 1'b1;
            end
         end

         if (fld_fall)
            line_ph <= '0;
         else if (hrf_fall)
            line_ph <= (line_ph == PH_W'(`VC_DECIM - 1)) ? '0 : line_ph + 1'b1;

         if (fld_fall)
            addr <= '0;                            // next field restarts at 0
         else if (keep)
            addr <= addr + 1'b1;

         if (fld_fall)
         begin
            bank     <= ~bank;                     // swap banks
            irq.bank <= bank;                      // report the filled one
         end
         irq.pulse <= fld_fall;                    // single cycle

         wr_en_q <= keep;
      end
   end

   // write payload
   always_ff @(posedge clk_llc)
   begin
      if (keep)
      begin
         wr_addr_q <= addr;
         wr_pix_q  <= pix;
      end
   end

   assign wr.en    = wr_en_q;
   assign wr.bank  = bank;
   assign wr.addr  = wr_addr_q;
   assign wr.pixel = wr_pix_q;

endmodule

// ==== hw/ycbcr_to_rgb565.sv ====
//----------------------------------------------------------
// ycbcr to rgb565, three stage fixed-point pipeline
//----------------------------------------------------------
`timescale 1ns/1ps
`include "vcap_params.svh"

module ycbcr_to_rgb565
(
   input  logic                   clk_llc,
   input  logic                   resetx,
   input  vcap_pkg::ycbcr_pair_t  pair,
   input  logic                   pair_valid,
   output vcap_pkg::rgb565_t      pix,
   output logic                   pix_valid
);

   localparam int ACC_W = 20;        // signed, 8 fractional bits
   localparam int FRAC  = 8;

   localparam logic signed [ACC_W-1:0] K_Y    = `VC_COEF_Y;
   localparam logic signed [ACC_W-1:0] K_CR_R = `VC_COEF_CR_R;
   localparam logic signed [ACC_W-1:0] K_CR_G = `VC_COEF_CR_G;
   localparam logic signed [ACC_W-1:0] K_CB_G = `VC_COEF_CB_G;
   localparam logic signed [ACC_W-1:0] K_CB_B = `VC_COEF_CB_B;
   localparam logic signed [ACC_W-1:0] Y_OFF  = `VC_Y_OFFSET;
   localparam logic signed [ACC_W-1:0] C_OFF  = `VC_C_OFFSET;

   // second pixel of the pair waits here one cycle
   logic [7:0] hold_y;
   logic [7:0] hold_cb;
   logic [7:0] hold_cr;
   logic       hold_v;

   logic [7:0]              s0_y;
   logic [7:0]              s0_cb;
   logic [7:0]              s0_cr;
   logic                    s0_v;
   logic signed [ACC_W-1:0] s0_yd;
   logic signed [ACC_W-1:0] s0_cbd;
   logic signed [ACC_W-1:0] s0_crd;

   logic signed [ACC_W-1:0] s1_luma;
   logic signed [ACC_W-1:0] s1_crr;
   logic signed [ACC_W-1:0] s1_crg;
   logic signed [ACC_W-1:0] s1_cbg;
   logic signed [ACC_W-1:0] s1_cbb;
   logic                    s1_v;

   logic signed [ACC_W-1:0] s2_r;
   logic signed [ACC_W-1:0] s2_g;
   logic signed [ACC_W-1:0] s2_b;
   logic                    s2_v;

   logic [7:0] r8;
   logic [7:0] g8;
   logic [7:0] b8;

   // clamp to 0..255, drop the fraction
   function automatic logic [7:0] sat8(input logic signed [ACC_W-1:0] v);
      if (v[ACC_W-1])
         return 8'h00;                          // negative
      else if (|v[ACC_W-2:FRAC+8])
         return 8'hff;                          // 256 or more
      else
         return v[FRAC+7:FRAC];
   endfunction

   //----------------------------------------------------------
   // issue: y0 with the pair, y1 one cycle later
   //----------------------------------------------------------
   always_ff @(posedge clk_llc)
   begin
      if (pair_valid)
      begin
         hold_y  <= pair.y1;
         hold_cb <= pair.cb;
         hold_cr <= pair.cr;
      end
   end

   always_comb
   begin
      if (pair_valid)
      begin
         s0_y  = pair.y0;
         s0_cb = pair.cb;
         s0_cr = pair.cr;
      end
      else
      begin
         s0_y  = hold_y;
         s0_cb = hold_cb;
         s0_cr = hold_cr;
      end
   end

   assign s0_v   = pair_valid | hold_v;
   assign s0_yd  = $signed({{(ACC_W-8){1'b0}}, s0_y})  - Y_OFF;
   assign s0_cbd = $signed({{(ACC_W-8){1'b0}}, s0_cb}) - C_OFF;
   assign s0_crd = $signed({{(ACC_W-8){1'b0}}, s0_cr}) - C_OFF;

   //----------------------------------------------------------
   // stage 1 products, stage 2 sums, stage 3 saturate
   //----------------------------------------------------------
   always_ff @(posedge clk_llc)
   begin
      s1_luma <= s0_yd  * K_Y;
      s1_crr  <= s0_crd * K_CR_R;
      s1_crg  <= s0_crd * K_CR_G;
      s1_cbg  <= s0_cbd * K_CB_G;
      s1_cbb  <= s0_cbd * K_CB_B;

      s2_r <= s1_luma + s1_crr;
      s2_g <= s1_luma - s1_crg - s1_cbg;
      s2_b <= s1_luma + s1_cbb;

      pix.r <= r8[7:3];                          // top 5 bits
      pix.g <= g8[7:2];                          // top 6 bits
      pix.b <= b8[7:3];
   end

   assign r8 = sat8(s2_r);
   assign g8 = sat8(s2_g);
   assign b8 = sat8(s2_b);

   // valid travels with the data
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         hold_v    <= 1'b0;
         s1_v      <= 1'b0;
         s2_v      <= 1'b0;
         pix_valid <= 1'b0;
      end
      else
      begin
         hold_v    <= pair_valid;
         s1_v      <= s0_v;
         s2_v      <= s1_v;
         pix_valid <= s2_v;
      end
   end

endmodule

// ==== hw/ycbcr_unpack.sv ====
//----------------------------------------------------------
// ycbcr 4:2:2 unpacker, byte stream to pixel pairs
//----------------------------------------------------------
`timescale 1ns/1ps

module ycbcr_unpack
(
   input  logic                   clk_llc,
   input  logic                   resetx,
   input  vcap_pkg::vid_in_t      vid,
   output vcap_pkg::ycbcr_pair_t  pair,
   output logic                   pair_valid
);

   vcap_pkg::byte_phase_e phase;
   vcap_pkg::byte_phase_e phase_nxt;
   logic                  capture;

   assign capture = vid.vref & vid.href & vid.odd;   // odd field, active line only

   // Cb -> Y0 -> Cr -> Y1 -> Cb ...
   always_comb
   begin
      case (phase)
         vcap_pkg::PH_CB : phase_nxt = vcap_pkg::PH_Y0;
         vcap_pkg::PH_Y0 : phase_nxt = vcap_pkg::PH_CR;
         vcap_pkg::PH_CR : phase_nxt = vcap_pkg::PH_Y1;
         default         : phase_nxt = vcap_pkg::PH_CB;
      endcase
   end

   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         phase      <= vcap_pkg::PH_CB;
         pair_valid <= 1'b0;
      end
      else
      begin
         phase      <= capture ? phase_nxt : vcap_pkg::PH_CB;  // restart in blanking
         pair_valid <= capture && (phase == vcap_pkg::PH_Y1);  // pair complete
      end
   end

   // byte latches
   always_ff @(posedge clk_llc)
   begin
      if (capture)
      begin
         case (phase)
            vcap_pkg::PH_CB : pair.cb <= vid.data;
            vcap_pkg::PH_Y0 : pair.y0 <= vid.data;
            vcap_pkg::PH_CR : pair.cr <= vid.data;
            default         : pair.y1 <= vid.data;   // closes the pair
         endcase
      end
   end

endmodule

// ==== hw/vcap_pkg.sv ====
//----------------------------------------------------------
// video capture types
// structs and enums shared by the capture chain
//----------------------------------------------------------
package vcap_pkg;

`include "vcap_params.svh"

   // one decoder clock
   typedef struct packed {
      logic       vref;              // field active
      logic       href;              // line active
      logic       odd;               // odd field
      logic [7:0] data;              // Cb Y Cr Y byte stream
   } vid_in_t;

   typedef struct packed {
      logic [7:0] y0;
      logic [7:0] y1;
      logic [7:0] cb;
      logic [7:0] cr;
   } ycbcr_pair_t;

   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } rgb565_t;

   // write port into the frame banks
   typedef struct packed {
      logic                  en;
      logic                  bank;   // bank being filled, valid every cycle
      logic [`VC_ADDR_W-1:0] addr;
      rgb565_t               pixel;
   } fb_write_t;

   typedef struct packed {
      logic [`VC_ADDR_W-1:0] addr;
   } rd_req_t;

   typedef struct packed {
      rgb565_t pixel;
   } rd_rsp_t;

   typedef struct packed {
      logic pulse;
      logic bank;                    // bank just finished
   } frame_irq_t;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_FETCH,
      RD_HOLD
   } rd_state_e;

   typedef enum logic [1:0] {
      PH_CB,
      PH_Y0,
      PH_CR,
      PH_Y1
   } byte_phase_e;

endpackage

// ==== hw/vcap_params.svh ====
//----------------------------------------------------------
// video capture parameters
// geometry, decimation, bank size and colour coefficients
//----------------------------------------------------------
`ifndef VCAP_PARAMS_SVH
`define VCAP_PARAMS_SVH

// source geometry, small for simulation
`define VC_SRC_WIDTH   12        // pixels per line
`define VC_SRC_LINES   6         // lines per field
`define VC_DECIM       3         // keep 1 of 3 in x and y

// frame bank
`define VC_BANK_WORDS  8         // 4 x 2 kept pixels
`define VC_ADDR_W      3         // word address inside a bank

// colour coefficients, 8 fractional bits
`define VC_COEF_Y      298       // 1.164
`define VC_COEF_CR_R   409       // 1.596
`define VC_COEF_CR_G   208       // 0.813
`define VC_COEF_CB_G   100       // 0.392
`define VC_COEF_CB_B   516       // 2.017

`define VC_Y_OFFSET    16        // luma black level
`define VC_C_OFFSET    128       // chroma zero

`endif
